// ==== logic/la32_pkg.sv ====
package la32_pkg;

    // Fetch starts here after reset.
    localparam logic [31:0] reset_pc = 32'h1c00_0000;

    // One instruction word, viewed through each encoding format.
    typedef union packed {
        struct packed {
            logic [5:0] op_31_26;
            logic [3:0] op_25_22;
            logic [1:0] op_21_20;
            logic [4:0] op_19_15;
            logic [4:0] rk;
            logic [4:0] rj;
            logic [4:0] rd;
        } r3;
        struct packed {
            logic [9:0]  opcode;
            logic [11:0] i12;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } ri12;
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] i16;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } ri16;
        struct packed {
            logic [6:0]  opcode;
            logic [19:0] i20;
            logic [4:0]  rd;
        } ri20;
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] offs_lo;
            logic [9:0]  offs_hi;
        } i26;
    } inst_u;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_and  = 4'd4,
        alu_nor  = 4'd5,
        alu_or   = 4'd6,
        alu_xor  = 4'd7,
        alu_sll  = 4'd8,
        alu_srl  = 4'd9,
        alu_sra  = 4'd10,
        alu_lui  = 4'd11
    } alu_op_e;

    // b and bl share the unconditional kind.
    typedef enum logic [2:0] {
        br_none = 3'd0,
        br_beq  = 3'd1,
        br_bne  = 3'd2,
        br_jump = 3'd3,
        br_jirl = 3'd4
    } br_kind_e;

    typedef struct packed {
        alu_op_e     alu_op;
        logic        src1_is_pc;
        logic        src2_is_imm;
        logic [31:0] imm;
        br_kind_e    br_kind;
        logic [31:0] br_offs;
        logic        res_from_mem;
        logic        gr_we;
        logic        mem_we;
        logic [4:0]  dest;
    } ctrl_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [3:0]  rf_we;
        logic [4:0]  wnum;
        logic [31:0] wdata;
    } trace_t;

endpackage

// ==== logic/inst_decode.sv ====
module inst_decode (
    input  la32_pkg::inst_u inst,
    output la32_pkg::ctrl_t ctrl,
    output logic [4:0]      raddr1,
    output logic [4:0]      raddr2
);

    logic is_3r;
    logic is_shift;

    logic inst_sub_w;
    logic inst_slt;
    logic inst_sltu;
    logic inst_nor;
    logic inst_and;
    logic inst_or;
    logic inst_xor;
    logic inst_slli_w;
    logic inst_srli_w;
    logic inst_srai_w;
    logic inst_addi_w;
    logic inst_ld_w;
    logic inst_st_w;
    logic inst_jirl;
    logic inst_b;
    logic inst_bl;
    logic inst_beq;
    logic inst_bne;
    logic inst_lu12i_w;

    logic need_i12;
    logic need_si20;
    logic need_si26;
    logic src2_is_4;
    logic src_reg_is_rd;

    // Shared prefixes of the register and shift-immediate groups.
    assign is_3r    = inst.r3.op_31_26 == 6'h00 && inst.r3.op_25_22 == 4'h0
                      && inst.r3.op_21_20 == 2'h1;
    assign is_shift = inst.r3.op_31_26 == 6'h00 && inst.r3.op_25_22 == 4'h1
                      && inst.r3.op_21_20 == 2'h0;

    assign inst_sub_w   = is_3r && inst.r3.op_19_15 == 5'h02;
    assign inst_slt     = is_3r && inst.r3.op_19_15 == 5'h04;
    assign inst_sltu    = is_3r && inst.r3.op_19_15 == 5'h05;
    assign inst_nor     = is_3r && inst.r3.op_19_15 == 5'h08;
    assign inst_and     = is_3r && inst.r3.op_19_15 == 5'h09;
    assign inst_or      = is_3r && inst.r3.op_19_15 == 5'h0a;
    assign inst_xor     = is_3r && inst.r3.op_19_15 == 5'h0b;
    assign inst_slli_w  = is_shift && inst.r3.op_19_15 == 5'h01;
    assign inst_srli_w  = is_shift && inst.r3.op_19_15 == 5'h09;
    assign inst_srai_w  = is_shift && inst.r3.op_19_15 == 5'h11;
    assign inst_addi_w  = inst.ri12.opcode == 10'h00a;
    assign inst_ld_w    = inst.ri12.opcode == 10'h0a2;
    assign inst_st_w    = inst.ri12.opcode == 10'h0a6;
    assign inst_jirl    = inst.ri16.opcode == 6'h13;
    assign inst_b       = inst.i26.opcode == 6'h14;
    assign inst_bl      = inst.i26.opcode == 6'h15;
    assign inst_beq     = inst.ri16.opcode == 6'h16;
    assign inst_bne     = inst.ri16.opcode == 6'h17;
    assign inst_lu12i_w = inst.ri20.opcode == 7'b0001010;

    assign need_i12      = inst_slli_w | inst_srli_w | inst_srai_w
                           | inst_addi_w | inst_ld_w | inst_st_w;
    assign need_si20     = inst_lu12i_w;
    assign need_si26     = inst_b | inst_bl;
    assign src2_is_4     = inst_jirl | inst_bl;
    assign src_reg_is_rd = inst_beq | inst_bne | inst_st_w;

    assign raddr1 = inst.r3.rj;
    assign raddr2 = src_reg_is_rd ? inst.r3.rd : inst.r3.rk;

    always_comb begin
        // Loads, stores and link writes all go through the adder.
        if (inst_sub_w)        ctrl.alu_op = la32_pkg::alu_sub;
        else if (inst_slt)     ctrl.alu_op = la32_pkg::alu_slt;
        else if (inst_sltu)    ctrl.alu_op = la32_pkg::alu_sltu;
        else if (inst_and)     ctrl.alu_op = la32_pkg::alu_and;
        else if (inst_nor)     ctrl.alu_op = la32_pkg::alu_nor;
        else if (inst_or)      ctrl.alu_op = la32_pkg::alu_or;
        else if (inst_xor)     ctrl.alu_op = la32_pkg::alu_xor;
        else if (inst_slli_w)  ctrl.alu_op = la32_pkg::alu_sll;
        else if (inst_srli_w)  ctrl.alu_op = la32_pkg::alu_srl;
        else if (inst_srai_w)  ctrl.alu_op = la32_pkg::alu_sra;
        else if (inst_lu12i_w) ctrl.alu_op = la32_pkg::alu_lui;
        else                   ctrl.alu_op = la32_pkg::alu_add;

        ctrl.src1_is_pc  = inst_jirl | inst_bl | inst_b;
        ctrl.src2_is_imm = need_i12 | inst_lu12i_w | inst_jirl | inst_bl | inst_b;

        if (src2_is_4)      ctrl.imm = 32'h4;
        else if (need_si20) ctrl.imm = {inst.ri20.i20, 12'b0};
        else if (need_i12)  ctrl.imm = {{20{inst.ri12.i12[11]}}, inst.ri12.i12};
        else                ctrl.imm = 32'h0;

        if (inst_beq)               ctrl.br_kind = la32_pkg::br_beq;
        else if (inst_bne)          ctrl.br_kind = la32_pkg::br_bne;
        else if (inst_b || inst_bl) ctrl.br_kind = la32_pkg::br_jump;
        else if (inst_jirl)         ctrl.br_kind = la32_pkg::br_jirl;
        else                        ctrl.br_kind = la32_pkg::br_none;

        // Word offsets, the 26-bit one split across two fields.
        if (need_si26) begin
            ctrl.br_offs = {{4{inst.i26.offs_hi[9]}}, inst.i26.offs_hi,
                            inst.i26.offs_lo, 2'b0};
        end else begin
            ctrl.br_offs = {{14{inst.ri16.i16[15]}}, inst.ri16.i16, 2'b0};
        end

        ctrl.res_from_mem = inst_ld_w;
        ctrl.gr_we        = ~(inst_st_w | inst_beq | inst_bne | inst_b);
        ctrl.mem_we       = inst_st_w;
        ctrl.dest         = inst_bl ? 5'd1 : inst.r3.rd;
    end

endmodule

// ==== logic/regfile.sv ====
module regfile (
    input  logic        clk,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    // r0 has no storage.
    logic [31:0] rf [1:31];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            rf[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? 32'h0 : rf[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'h0 : rf[raddr2];

endmodule

// ==== logic/alu.sv ====
module alu (
    input  la32_pkg::ctrl_t ctrl,
    input  logic [31:0]     pc,
    input  logic [31:0]     rj_value,
    input  logic [31:0]     rkd_value,
    output logic [31:0]     alu_result
);

    logic [31:0] src1;
    logic [31:0] src2;
    logic [4:0]  shamt;

    assign src1  = ctrl.src1_is_pc ? pc : rj_value;
    assign src2  = ctrl.src2_is_imm ? ctrl.imm : rkd_value;
    assign shamt = src2[4:0];

    always_comb begin
        case (ctrl.alu_op)
            la32_pkg::alu_add:  alu_result = src1 + src2;
            la32_pkg::alu_sub:  alu_result = src1 - src2;
            la32_pkg::alu_slt:  alu_result = {31'b0, $signed(src1) < $signed(src2)};
            la32_pkg::alu_sltu: alu_result = {31'b0, src1 < src2};
            la32_pkg::alu_and:  alu_result = src1 & src2;
            la32_pkg::alu_nor:  alu_result = ~(src1 | src2);
            la32_pkg::alu_or:   alu_result = src1 | src2;
            la32_pkg::alu_xor:  alu_result = src1 ^ src2;
            la32_pkg::alu_sll:  alu_result = src1 << shamt;
            la32_pkg::alu_srl:  alu_result = src1 >> shamt;
            la32_pkg::alu_sra:  alu_result = $unsigned($signed(src1) >>> shamt);
            // lu12i.w already carries its value in the immediate.
            la32_pkg::alu_lui:  alu_result = src2;
            default:            alu_result = 32'h0;
        endcase
    end

endmodule

// ==== logic/branch_unit.sv ====
module branch_unit (
    input  la32_pkg::ctrl_t ctrl,
    input  logic [31:0]     pc,
    input  logic [31:0]     rj_value,
    input  logic [31:0]     rkd_value,
    output logic            br_taken,
    output logic [31:0]     br_target
);

    logic        rj_eq_rd;
    logic [31:0] target_base;

    // rkd_value holds rd for beq and bne.
    assign rj_eq_rd = (rj_value == rkd_value);

    always_comb begin
        case (ctrl.br_kind)
            la32_pkg::br_beq:  br_taken = rj_eq_rd;
            la32_pkg::br_bne:  br_taken = ~rj_eq_rd;
            la32_pkg::br_jump: br_taken = 1'b1;
            la32_pkg::br_jirl: br_taken = 1'b1;
            default:           br_taken = 1'b0;
        endcase
    end

    assign target_base = (ctrl.br_kind == la32_pkg::br_jirl) ? rj_value : pc;
    assign br_target   = target_base + ctrl.br_offs;

endmodule

// ==== logic/commit_unit.sv ====
module commit_unit (
    input  logic               clk,
    input  logic               reset,
    input  la32_pkg::ctrl_t    ctrl,
    input  logic [31:0]        alu_result,
    input  logic               br_taken,
    input  logic [31:0]        br_target,
    input  logic [31:0]        mem_rdata,
    output logic [31:0]        pc,
    output logic               rf_we,
    output logic [4:0]         rf_waddr,
    output logic [31:0]        rf_wdata,
    output logic               mem_we,
    output la32_pkg::trace_t   trace
);

    logic        valid;
    logic        redirect;
    logic [31:0] seq_pc;
    logic [31:0] next_pc;

    assign seq_pc   = pc + 32'd4;
    assign redirect = br_taken && valid;
    assign next_pc  = redirect ? br_target : seq_pc;

    // The first fetch waits one cycle after reset.
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
            pc    <= la32_pkg::reset_pc;
        end else begin
            valid <= 1'b1;
            if (valid) begin
                pc <= next_pc;
            end
        end
    end

    assign rf_we    = ctrl.gr_we && valid;
    assign rf_waddr = ctrl.dest;
    assign rf_wdata = ctrl.res_from_mem ? mem_rdata : alu_result;
    assign mem_we   = ctrl.mem_we && valid;

    always_comb begin
        trace.pc    = pc;
        trace.rf_we = {4{rf_we}};
        trace.wnum  = rf_waddr;
        trace.wdata = rf_wdata;
    end

endmodule

// ==== logic/mycpu_top.sv ====
module mycpu_top (
    input  logic        clk,
    input  logic        reset,
    output logic        inst_sram_we,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] inst_sram_wdata,
    input  logic [31:0] inst_sram_rdata,
    output logic        data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    la32_pkg::ctrl_t  ctrl;
    la32_pkg::trace_t trace;

    logic [4:0]  raddr1;
    logic [4:0]  raddr2;
    logic [31:0] rj_value;
    logic [31:0] rkd_value;
    logic [31:0] alu_result;
    logic        br_taken;
    logic [31:0] br_target;
    logic [31:0] pc;
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;

    // Instruction memory is read only.
    assign inst_sram_we    = 1'b0;
    assign inst_sram_addr  = pc;
    assign inst_sram_wdata = 32'h0;

    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = rkd_value;

    inst_decode u_inst_decode (
        .inst   (inst_sram_rdata),
        .ctrl   (ctrl),
        .raddr1 (raddr1),
        .raddr2 (raddr2)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rj_value),
        .rdata2 (rkd_value),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    alu u_alu (
        .ctrl       (ctrl),
        .pc         (pc),
        .rj_value   (rj_value),
        .rkd_value  (rkd_value),
        .alu_result (alu_result)
    );

    branch_unit u_branch_unit (
        .ctrl      (ctrl),
        .pc        (pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

    commit_unit u_commit_unit (
        .clk        (clk),
        .reset      (reset),
        .ctrl       (ctrl),
        .alu_result (alu_result),
        .br_taken   (br_taken),
        .br_target  (br_target),
        .mem_rdata  (data_sram_rdata),
        .pc         (pc),
        .rf_we      (rf_we),
        .rf_waddr   (rf_waddr),
        .rf_wdata   (rf_wdata),
        .mem_we     (data_sram_we),
        .trace      (trace)
    );

    assign debug_wb_pc       = trace.pc;
    assign debug_wb_rf_we    = trace.rf_we;
    assign debug_wb_rf_wnum  = trace.wnum;
    assign debug_wb_rf_wdata = trace.wdata;

endmodule

// ==== test/tb_mycpu_top.sv ====
module tb_mycpu_top;
    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        reset;
    logic        inst_sram_we;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] gpr [32];
    logic [31:0] ref_mem [256];
    logic [31:0] ref_pc;
    logic [31:0] final_pc;
    logic        exp_store;
    logic [31:0] exp_addr;
    logic [31:0] exp_sdata;
    logic        core_live;
    logic        prog_ready;
    int          prog_len;
    int          n_checks;
    int          n_errors;
    logic [4:0]  r3_ops [8] = '{5'h00, 5'h02, 5'h04, 5'h05, 5'h08, 5'h09, 5'h0a, 5'h0b};
    logic [4:0]  shift_ops [3] = '{5'h01, 5'h09, 5'h11};

    mycpu_top DUT (.*);

    initial begin : clock_gen
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin : reset_gen
        reset <= 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    end

    // Both SRAMs read combinationally.
    assign inst_sram_rdata = imem[inst_sram_addr[9:2]];
    assign data_sram_rdata = dmem[data_sram_addr[9:2]];

    always @(posedge clk) begin
        if (data_sram_we) begin
            dmem[data_sram_addr[9:2]] <= data_sram_wdata;
        end
    end

    // Valid is expected one edge after reset is seen low.
    always @(posedge clk) begin
        core_live <= !reset;
    end

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    function automatic logic [4:0] pick_reg();
        return 5'($urandom % 16);
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[8'(prog_len)] = word;
        prog_len++;
    endtask

    task automatic put_3r(input logic [4:0] op, input logic [4:0] rd, input logic [4:0] rj,
                          input logic [4:0] rk);
        emit({6'h00, 4'h0, 2'h1, op, rk, rj, rd});
    endtask

    task automatic put_shift(input logic [4:0] op, input logic [4:0] rd, input logic [4:0] rj,
                             input logic [4:0] ui5);
        emit({6'h00, 4'h1, 2'h0, op, ui5, rj, rd});
    endtask

    task automatic put_ri12(input logic [9:0] op, input logic [4:0] rd, input logic [4:0] rj,
                            input logic [11:0] si12);
        emit({op, si12, rj, rd});
    endtask

    task automatic put_ri16(input logic [5:0] op, input logic [4:0] rd, input logic [4:0] rj,
                            input logic [15:0] offs);
        emit({op, offs, rj, rd});
    endtask

    task automatic put_i26(input logic [5:0] op, input logic [25:0] offs);
        emit({op, offs[15:0], offs[25:16]});
    endtask

    task automatic put_lu12i(input logic [4:0] rd, input logic [19:0] si20);
        emit({7'b0001010, si20, rd});
    endtask

    task automatic put_random_alu();
        put_3r(r3_ops[3'($urandom % 8)], pick_reg(), pick_reg(), pick_reg());
    endtask

    task automatic build_program();
        int          kind;
        int          skip;
        logic [11:0] offs;
        logic [4:0]  ra;
        logic [4:0]  rb;
        prog_len = 0;
        for (int r = 1; r < 16; r++) begin
            put_lu12i(5'(r), 20'($urandom));
            put_ri12(10'h00a, 5'(r), 5'(r), 12'($urandom));
        end
        // r31 is the data window base.
        put_ri12(10'h00a, 5'd31, 5'd0, 12'h200);
        while (prog_len < 236) begin
            kind = int'($urandom % 10);
            skip = int'($urandom % 3) + 1;
            case (kind)
                0, 1, 2: put_random_alu();
                3: put_shift(shift_ops[2'($urandom % 3)], pick_reg(), pick_reg(), 5'($urandom));
                4: put_ri12(10'h00a, pick_reg(), pick_reg(), 12'($urandom));
                5: put_lu12i(pick_reg(), 20'($urandom));
                6: begin
                    offs = 12'(($urandom % 256) * 4) - 12'h200;
                    ra = pick_reg();
                    put_ri12(10'h0a6, ra, 5'd31, offs);
                    put_ri12(10'h0a2, pick_reg(), 5'd31, offs);
                end
                7: begin
                    ra = pick_reg();
                    rb = ($urandom % 2 == 0) ? ra : pick_reg();
                    put_ri16(($urandom % 2 == 0) ? 6'h16 : 6'h17, rb, ra, 16'(skip + 1));
                    repeat (skip) put_random_alu();
                end
                8: begin
                    put_i26(($urandom % 2 == 0) ? 6'h14 : 6'h15, 26'(skip + 1));
                    repeat (skip) put_random_alu();
                end
                default: begin
                    // Absolute target, counted in words from the reset pc.
                    put_lu12i(5'd13, 20'h1c000);
                    put_ri16(6'h13, pick_reg(), 5'd13, 16'(prog_len + 1 + skip));
                    repeat (skip) put_random_alu();
                end
            endcase
        end
        final_pc = la32_pkg::reset_pc + 32'(4 * prog_len);
        put_i26(6'h14, 26'd0);
    endtask

    // ISA model, one retired instruction per call.
    function automatic la32_pkg::trace_t model_step();
        la32_pkg::trace_t t;
        logic [31:0] ir;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] d;
        logic [31:0] offs16;
        logic [31:0] offs26;
        logic [31:0] next_pc;
        logic [31:0] res;
        logic        we;
        logic [4:0]  wnum;
        ir = imem[ref_pc[9:2]];
        a = gpr[ir[9:5]];
        b = gpr[ir[14:10]];
        d = gpr[ir[4:0]];
        offs16 = {{14{ir[25]}}, ir[25:10], 2'b00};
        offs26 = {{4{ir[9]}}, ir[9:0], ir[25:10], 2'b00};
        next_pc = ref_pc + 32'd4;
        res = 32'h0;
        we = 1'b1;
        wnum = ir[4:0];
        exp_store = 1'b0;
        exp_addr = a + {{20{ir[21]}}, ir[21:10]};
        exp_sdata = d;
        case (ir[31:15])
            17'h00020: res = a + b;
            17'h00022: res = a - b;
            17'h00024: res = {31'b0, $signed(a) < $signed(b)};
            17'h00025: res = {31'b0, a < b};
            17'h00028: res = ~(a | b);
            17'h00029: res = a & b;
            17'h0002a: res = a | b;
            17'h0002b: res = a ^ b;
            17'h00081: res = a << ir[14:10];
            17'h00089: res = a >> ir[14:10];
            17'h00091: res = $signed(a) >>> ir[14:10];
            default: begin
                case (ir[31:22])
                    10'h00a: res = exp_addr;
                    10'h0a2: res = ref_mem[exp_addr[9:2]];
                    10'h0a6: begin
                        we = 1'b0;
                        exp_store = 1'b1;
                        ref_mem[exp_addr[9:2]] = d;
                    end
                    default: begin
                        case (ir[31:26])
                            6'h13: begin
                                res = ref_pc + 32'd4;
                                next_pc = a + offs16;
                            end
                            6'h14: begin
                                we = 1'b0;
                                next_pc = ref_pc + offs26;
                            end
                            6'h15: begin
                                wnum = 5'd1;
                                res = ref_pc + 32'd4;
                                next_pc = ref_pc + offs26;
                            end
                            6'h16, 6'h17: begin
                                we = 1'b0;
                                if ((a == d) == (ir[31:26] == 6'h16)) begin
                                    next_pc = ref_pc + offs16;
                                end
                            end
                            default: res = {ir[24:5], 12'h000};
                        endcase
                    end
                endcase
            end
        endcase
        if (we && wnum != 5'd0) begin
            gpr[wnum] = res;
        end
        t.pc = ref_pc;
        t.rf_we = {4{we}};
        t.wnum = wnum;
        t.wdata = res;
        ref_pc = next_pc;
        return t;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        n_checks++;
        assert (actual === expected) else begin
            n_errors++;
            $display("error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    initial begin : program_setup
        prog_ready = 1'b0;
        n_checks = 0;
        n_errors = 0;
        void'($urandom(32'hb480_8409));
        for (int i = 0; i < 256; i++) begin
            imem[8'(i)] = 32'h0;
            dmem[8'(i)] <= fill_word(32'(i * 4));
            ref_mem[8'(i)] = fill_word(32'(i * 4));
        end
        for (int i = 0; i < 32; i++) begin
            gpr[5'(i)] = 32'h0;
        end
        ref_pc = la32_pkg::reset_pc;
        build_program();
        prog_ready = 1'b1;
    end

    initial begin : compare_trace
        la32_pkg::trace_t want;
        int tail;
        tail = 0;
        wait (prog_ready);
        @(posedge clk);
        while (tail < 4) begin
            @(negedge clk);
            check_value("inst_sram_we", 32'h0, {31'h0, inst_sram_we});
            check_value("inst_sram_wdata", 32'h0, inst_sram_wdata);
            if (!core_live) begin
                check_value("debug_wb_pc", la32_pkg::reset_pc, debug_wb_pc);
                check_value("inst_sram_addr", la32_pkg::reset_pc, inst_sram_addr);
                check_value("debug_wb_rf_we", 32'h0, {28'h0, debug_wb_rf_we});
                check_value("data_sram_we", 32'h0, {31'h0, data_sram_we});
            end else begin
                want = model_step();
                check_value("debug_wb_pc", want.pc, debug_wb_pc);
                check_value("inst_sram_addr", want.pc, inst_sram_addr);
                check_value("debug_wb_rf_we", {28'h0, want.rf_we}, {28'h0, debug_wb_rf_we});
                if (want.rf_we[0]) begin
                    check_value("debug_wb_rf_wnum", {27'h0, want.wnum},
                                {27'h0, debug_wb_rf_wnum});
                    check_value("debug_wb_rf_wdata", want.wdata, debug_wb_rf_wdata);
                end
                check_value("data_sram_we", {31'h0, exp_store}, {31'h0, data_sram_we});
                if (exp_store) begin
                    check_value("data_sram_addr", exp_addr, data_sram_addr);
                    check_value("data_sram_wdata", exp_sdata, data_sram_wdata);
                end
                if (want.pc == final_pc) begin
                    tail++;
                end
            end
        end
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin : watchdog
        wait (prog_ready);
        #((8 + prog_len + 20) * 20);
        n_errors++;
        $display("timeout: the core did not reach the final branch in time");
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== flist.f ====
logic/la32_pkg.sv
logic/inst_decode.sv
logic/regfile.sv
logic/alu.sv
logic/branch_unit.sv
logic/commit_unit.sv
logic/mycpu_top.sv
test/tb_mycpu_top.sv

// ==== run.sh ====
#!/bin/sh
# Builds the core testbench with Verilator, runs it and judges the log.
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps --top-module tb_mycpu_top \
    -f flist.f -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "simulation reported failures"
    exit 1
fi
exit 0
